//--- design/icache_geom_pkg.sv
package icache_geom_pkg;

    // Fetch word and line shape
    localparam int word_width = 32;
    localparam int line_words = 4;
    localparam int line_width = word_width * line_words;   // 128 bit line

    // Cache organisation
    localparam int num_ways = 2;
    localparam int num_sets = 32;
    localparam int way_bits = 1;                            // Way select width

    // Byte address split, high to low
    localparam int tag_bits    = 23;
    localparam int index_bits  = 5;
    localparam int offset_bits = 2;                         // Word within line
    localparam int byte_bits   = 2;                         // Byte within word

    // Overlays a 32-bit byte address
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
        logic [byte_bits-1:0]   byte_sel;   // Unused by lookup
    } icache_addr_t;

endpackage

//--- design/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // Hit and miss counters, also the read data width
    localparam int counter_width = 16;

    // Miss handling
    typedef enum logic [1:0] {
        refill_idle,
        refill_request,     // Line request out, waiting on memory
        refill_allocate     // Line written, lookup settles
    } refill_state_t;

    // Register block operations
    typedef enum logic [1:0] {
        csr_read_hits   = 2'd0,
        csr_read_misses = 2'd1,
        csr_clear       = 2'd2,     // Zero both counters
        csr_flush       = 2'd3      // Drop all valid lines
    } csr_op_t;

    // Single-cycle command strobe
    typedef struct packed {
        logic    valid;
        csr_op_t op;
    } csr_cmd_t;

endpackage

//--- design/icache_tag_store.sv
module icache_tag_store (
    input  logic                                   clk,
    input  logic                                   reset,
    input  icache_geom_pkg::icache_addr_t          addr,
    input  logic                                   lookup,
    input  logic                                   alloc,
    input  logic                                   flush,
    output logic                                   hit,
    output logic [icache_geom_pkg::way_bits-1:0]   hit_way,
    output logic [icache_geom_pkg::way_bits-1:0]   alloc_way
);
    import icache_geom_pkg::*;

    logic [tag_bits-1:0]               tag_array [num_sets][num_ways];
    logic [num_sets-1:0][num_ways-1:0] valid;
    logic [num_sets-1:0]               rr_bit;     // Next victim per set
    logic [num_ways-1:0]               way_match;

    // Compare every way of the indexed set
    always_comb begin
        way_match = '0;
        hit_way   = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid[addr.index][w] && (tag_array[addr.index][w] == addr.tag)) begin
                way_match[w] = 1'b1;
                hit_way      = w[way_bits-1:0];
            end
        end
    end

    assign hit       = lookup && (|way_match);
    assign alloc_way = rr_bit[addr.index];   // Round-robin victim

    // Tag write into the victim way
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_array[addr.index][alloc_way] <= addr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid  <= '0;
            rr_bit <= '0;
        end else if (flush) begin
            valid  <= '0;                    // Whole cache invalid
            rr_bit <= '0;
        end else if (alloc) begin
            valid[addr.index][alloc_way] <= 1'b1;
            rr_bit[addr.index]           <= ~rr_bit[addr.index];
        end
    end

endmodule

//--- design/icache_data_store.sv
module icache_data_store (
    input  logic                                     clk,
    input  icache_geom_pkg::icache_addr_t            addr,
    input  logic [icache_geom_pkg::way_bits-1:0]     hit_way,
    input  logic                                     alloc,
    input  logic [icache_geom_pkg::way_bits-1:0]     alloc_way,
    input  logic [icache_geom_pkg::line_width-1:0]   fetch_data,
    output logic [icache_geom_pkg::word_width-1:0]   cache_read
);
    import icache_geom_pkg::*;

    logic [line_width-1:0] line_array [num_sets][num_ways];
    logic [line_width-1:0] hit_line;

    // Whole line lands in one write
    always_ff @(posedge clk) begin
        if (alloc) begin
            line_array[addr.index][alloc_way] <= fetch_data;
        end
    end

    // Word 0 sits in the low bits of the line
    always_comb begin
        hit_line   = line_array[addr.index][hit_way];
        cache_read = hit_line[addr.offset*word_width +: word_width];
    end

endmodule

//--- design/icache_refill.sv
module icache_refill (
    input  logic                                     clk,
    input  logic                                     reset,
    input  icache_geom_pkg::icache_addr_t            addr,
    input  logic                                     lookup,
    input  logic                                     hit,
    input  logic                                     fetch_enable,
    output logic                                     fetch_request,
    output logic [icache_geom_pkg::word_width-1:0]   fetch_addr,
    output logic                                     alloc,
    output logic                                     miss_event
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    refill_state_t state;
    icache_addr_t  line_addr;

    // Line aligned request address
    always_comb begin
        line_addr          = addr;
        line_addr.offset   = '0;
        line_addr.byte_sel = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= refill_idle;
            fetch_request <= 1'b0;
            fetch_addr    <= '0;
        end else begin
            case (state)
                refill_idle: begin
                    if (lookup && !hit) begin
                        state         <= refill_request;
                        fetch_request <= 1'b1;
                        fetch_addr    <= line_addr;   // Held until memory answers
                    end
                end
                refill_request: begin
                    // Memory may take any number of cycles
                    if (fetch_enable) begin
                        state         <= refill_allocate;
                        fetch_request <= 1'b0;
                    end
                end
                refill_allocate: begin
                    state <= refill_idle;   // One cycle for the lookup to settle
                end
                default: begin
                    state <= refill_idle;
                end
            endcase
        end
    end

    // Line write happens on the edge after the strobe
    assign alloc      = (state == refill_request) && fetch_enable;
    assign miss_event = alloc;

endmodule

//--- design/icache_csr.sv
module icache_csr (
    input  logic                                        clk,
    input  logic                                        reset,
    input  icache_ctrl_pkg::csr_cmd_t                   csr_cmd,
    input  logic                                        hit,
    input  logic                                        miss_event,
    output logic [icache_ctrl_pkg::counter_width-1:0]   csr_rdata,
    output logic                                        flush
);
    import icache_ctrl_pkg::*;

    logic [counter_width-1:0] hit_count;
    logic [counter_width-1:0] miss_count;
    logic                     clear;

    assign clear = csr_cmd.valid && (csr_cmd.op == csr_clear);
    assign flush = csr_cmd.valid && (csr_cmd.op == csr_flush);   // Tag store acts on next edge

    // Saturating event counters
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit && (hit_count != '1)) begin
                hit_count <= hit_count + 1'b1;
            end
            if (miss_event && (miss_count != '1)) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (reset) begin
            csr_rdata <= '0;
        end else if (csr_cmd.valid) begin
            case (csr_cmd.op)
                csr_read_hits:   csr_rdata <= hit_count;
                csr_read_misses: csr_rdata <= miss_count;
                default:         csr_rdata <= csr_rdata;
            endcase
        end
    end

endmodule

//--- design/icache_top.sv
module icache_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        lookup,
    input  logic [icache_geom_pkg::word_width-1:0]      addr,
    output logic                                        hit,
    output logic [icache_geom_pkg::word_width-1:0]      cache_read,
    output logic                                        fetch_request,
    output logic [icache_geom_pkg::word_width-1:0]      fetch_addr,
    input  logic [icache_geom_pkg::line_width-1:0]      fetch_data,
    input  logic                                        fetch_enable,
    input  icache_ctrl_pkg::csr_cmd_t                   csr_cmd,
    output logic [icache_ctrl_pkg::counter_width-1:0]   csr_rdata
);
    import icache_geom_pkg::*;

    icache_addr_t        addr_fields;   // Byte address split into fields
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] alloc_way;
    logic                alloc;
    logic                miss_event;
    logic                flush;

    assign addr_fields = addr;

    icache_tag_store tag_store_i (
        .clk(clk), .reset(reset), .addr(addr_fields), .lookup(lookup),
        .alloc(alloc), .flush(flush), .hit(hit), .hit_way(hit_way),
        .alloc_way(alloc_way)
    );

    icache_data_store data_store_i (
        .clk(clk), .addr(addr_fields), .hit_way(hit_way), .alloc(alloc),
        .alloc_way(alloc_way), .fetch_data(fetch_data), .cache_read(cache_read)
    );

    icache_refill refill_i (
        .clk(clk), .reset(reset), .addr(addr_fields), .lookup(lookup), .hit(hit),
        .fetch_enable(fetch_enable), .fetch_request(fetch_request),
        .fetch_addr(fetch_addr), .alloc(alloc), .miss_event(miss_event)
    );

    icache_csr csr_i (
        .clk(clk), .reset(reset), .csr_cmd(csr_cmd), .hit(hit),
        .miss_event(miss_event), .csr_rdata(csr_rdata), .flush(flush)
    );

endmodule

//--- sim/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Period of 100 time units
    always begin
        #50 clk = ~clk;
    end

endmodule

//--- sim/icache_tb.sv
module icache_tb;
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int num_random      = 400;
    localparam int num_accesses    = num_random + 20;
    localparam int timeout_cycles  = num_accesses * 20 + 500;
    localparam int max_fetch_wait  = 16;

    logic                     clk;
    logic                     reset;
    logic                     lookup;
    logic [word_width-1:0]    addr;
    logic                     hit;
    logic [word_width-1:0]    cache_read;
    logic                     fetch_request;
    logic [word_width-1:0]    fetch_addr;
    logic [line_width-1:0]    fetch_data;
    logic                     fetch_enable;
    csr_cmd_t                 csr_cmd;
    logic [counter_width-1:0] csr_rdata;

    // Reference copy of tags, valid and round-robin bits
    logic [tag_bits-1:0] ref_tag [num_sets][num_ways];
    logic                ref_valid [num_sets][num_ways];
    logic                ref_rr [num_sets];

    logic                check_en;
    logic                exp_hit;
    logic [31:0]         exp_data;
    int                  exp_hits;     // Hit cycles expected so far
    int                  hit_base;     // Value of exp_hits at last clear
    int                  exp_misses;

    tb_clock clock_i (.clk(clk));

    icache_top icache_top_i (
        .clk(clk), .reset(reset), .lookup(lookup), .addr(addr), .hit(hit),
        .cache_read(cache_read), .fetch_request(fetch_request), .fetch_addr(fetch_addr),
        .fetch_data(fetch_data), .fetch_enable(fetch_enable), .csr_cmd(csr_cmd),
        .csr_rdata(csr_rdata)
    );

    // Memory word as a mix of the full byte address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [line_width-1:0] make_line(input logic [31:0] line_addr);
        logic [line_width-1:0] line;
        for (int i = 0; i < line_words; i++) begin
            line[i*word_width +: word_width] = mem_word(line_addr + 32'(i * 4));
        end
        return line;
    endfunction

    // Way holding the address or -1 on a miss
    function automatic int ref_hit_way(input logic [31:0] a);
        icache_addr_t f;
        int           result;
        f = a;
        result = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[f.index][w] && (ref_tag[f.index][w] == f.tag)) begin
                result = w;
            end
        end
        return result;
    endfunction

    task automatic ref_allocate(input logic [31:0] a);
        icache_addr_t f;
        logic         victim;
        f = a;
        victim = ref_rr[f.index];
        ref_tag[f.index][victim]   = f.tag;
        ref_valid[f.index][victim] = 1'b1;
        ref_rr[f.index]            = ~victim;
    endtask

    task automatic ref_flush();
        for (int s = 0; s < num_sets; s++) begin
            ref_rr[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            stop_run();
        end
    endtask

    // One lookup with refill on a predicted miss
    task automatic access(input logic [31:0] a);
        int way;
        int waited;
        way = ref_hit_way(a);
        @(negedge clk);
        lookup   = 1'b1;
        addr     = a;
        exp_hit  = (way >= 0);
        exp_data = mem_word(a);
        check_en = 1'b1;
        @(posedge clk);
        if (way < 0) begin
            @(posedge clk);                  // Request is up one cycle after the miss
            check_value("fetch_request", 32'(fetch_request), 32'd1);
            check_value("fetch_addr", fetch_addr, a & 32'hffff_fff0);
            waited = 0;
            while (!fetch_enable) begin
                @(posedge clk);
                waited++;
                if (waited > max_fetch_wait) begin
                    $display("Memory strobe did not arrive for address %h", a);
                    stop_run();
                end
            end
            check_value("fetch_request", 32'(fetch_request), 32'd1);
            ref_allocate(a);
            exp_misses++;
            @(negedge clk);
            exp_hit = 1'b1;                  // Line is in place after the strobe edge
            @(posedge clk);
        end
        check_value("fetch_request", 32'(fetch_request), 32'd0);   // No request outstanding
        @(negedge clk);
        lookup   = 1'b0;
        check_en = 1'b0;
    endtask

    task automatic issue_cmd(input csr_op_t op);
        @(negedge clk);
        csr_cmd.valid = 1'b1;
        csr_cmd.op    = op;
        @(negedge clk);
        csr_cmd = '0;
    endtask

    task automatic read_counter(input csr_op_t op, input int expected);
        issue_cmd(op);
        check_value("csr_rdata", 32'(csr_rdata), 32'(expected));
    endtask

    function automatic logic [31:0] random_addr();
        logic [31:0] a;
        a = 32'h0001_0000;
        a = a | ($urandom_range(0, 3) << 9);   // Tag
        a = a | ($urandom_range(0, 3) << 4);   // Index
        a = a | ($urandom_range(0, 3) << 2);   // Offset
        return a;
    endfunction

    // Compares the lookup result on every rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (check_en) begin
                check_value("hit", 32'(hit), 32'(exp_hit));
                if (exp_hit) begin
                    check_value("cache_read", cache_read, exp_data);
                    exp_hits++;
                end
            end else begin
                check_value("hit", 32'(hit), 32'd0);
            end
        end
    end

    // Memory answers after 1 to 8 cycles
    always begin
        int delay;
        @(posedge clk);
        if (fetch_request) begin
            delay = $urandom_range(1, 8);
            repeat (delay - 1) @(posedge clk);
            @(negedge clk);
            fetch_data   = make_line(fetch_addr);
            fetch_enable = 1'b1;
            @(negedge clk);
            fetch_enable = 1'b0;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the test did not complete", timeout_cycles);
        stop_run();
    end

    initial begin
        void'($urandom(32'h5923b8b9));
        reset        = 1'b1;
        lookup       = 1'b0;
        addr         = '0;
        fetch_data   = '0;
        fetch_enable = 1'b0;
        csr_cmd      = '0;
        check_en     = 1'b0;
        exp_hit      = 1'b0;
        exp_data     = '0;
        exp_hits     = 0;
        hit_base     = 0;
        exp_misses   = 0;
        ref_flush();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Cold miss followed by all words of the same line
        access(32'h0000_1004);
        for (int i = 0; i < line_words; i++) begin
            access(32'h0000_1000 + 32'(i * 4));
        end

        // Third of three tags in set 4 evicts the first
        access(32'h0000_2040);
        access(32'h0000_4040);
        access(32'h0000_6040);
        access(32'h0000_4048);
        access(32'h0000_2044);

        for (int i = 0; i < num_random; i++) begin
            access(random_addr());
        end

        read_counter(csr_read_hits, exp_hits - hit_base);
        read_counter(csr_read_misses, exp_misses);
        issue_cmd(csr_clear);
        hit_base   = exp_hits;
        exp_misses = 0;
        read_counter(csr_read_hits, 0);
        read_counter(csr_read_misses, 0);

        // Resident lines must refill after a flush
        issue_cmd(csr_flush);
        ref_flush();
        access(32'h0000_1008);
        access(32'h0000_4040);
        read_counter(csr_read_misses, exp_misses);
        read_counter(csr_read_hits, exp_hits - hit_base);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- all.f
design/icache_geom_pkg.sv
design/icache_ctrl_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_refill.sv
design/icache_csr.sv
design/icache_top.sv
sim/tb_clock.sv
sim/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= icache_tb
FILE_LIST ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
